//--- design/soc_pkg.sv
`default_nettype none

package soc_pkg;

  ////////////////////////////////////////////////////////////
  // Address map and sizes
  ////////////////////////////////////////////////////////////

  localparam int unsigned RAM_SIZE  = 1024;            // Bytes.
  localparam int unsigned RAM_WORDS = RAM_SIZE / 4;
  localparam int unsigned RAM_AW    = $clog2(RAM_WORDS);

  localparam logic [31:0] PERIPH_BASE = 32'h8000_0000;
  localparam logic [31:0] PERIPH_END  = 32'h8000_6000; // First address past the window.

  // Address bits 15 to 12 pick the peripheral inside the window.
  localparam logic [3:0] LED_PAGE = 4'd1;
  localparam logic [3:0] HEX_PAGE = 4'd2;

  localparam int unsigned HEX_SCAN_BITS = 2;           // Four clocks per digit.

  localparam logic IRQ_CAUSE_FLAG = 1'b1;

  ////////////////////////////////////////////////////////////
  // Bus and register types
  ////////////////////////////////////////////////////////////

  typedef struct packed {
    logic        req;
    logic        we;
    logic [3:0]  be;
    logic [31:0] addr;
    logic [31:0] wdata;
  } bus_req_t;

  typedef enum logic [1:0] {
    RDSEL_NONE,
    RDSEL_MEM,
    RDSEL_LEDS,
    RDSEL_HEX
  } rdsel_e;

  // The bus writes this word by byte lanes, the scanner reads it by digits.
  typedef union packed {
    logic [1:0][7:0] bytes;
    logic [3:0][3:0] digits;
  } hex_word_u;

endpackage

`default_nettype wire

//--- design/addr_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module addr_decoder (
  input  soc_pkg::bus_req_t bus_i,
  output logic              ram_we_o,
  output logic              led_we_o,
  output logic              hex_we_o,
  output soc_pkg::rdsel_e   rdsel_o
);

  logic       in_ram;
  logic       in_periph;
  logic [3:0] page;
  logic       wr;

  assign in_ram    = bus_i.addr < soc_pkg::RAM_SIZE;
  assign in_periph = (bus_i.addr >= soc_pkg::PERIPH_BASE) &&
                     (bus_i.addr <  soc_pkg::PERIPH_END);
  assign page      = bus_i.addr[15:12];
  assign wr        = bus_i.req && bus_i.we;

  // Target selection. Invalid addresses and empty pages fall to NONE.
  always_comb begin
    rdsel_o = soc_pkg::RDSEL_NONE;
    if (in_ram) begin
      rdsel_o = soc_pkg::RDSEL_MEM;
    end else if (in_periph) begin
      case (page)
        soc_pkg::LED_PAGE: rdsel_o = soc_pkg::RDSEL_LEDS;
        soc_pkg::HEX_PAGE: rdsel_o = soc_pkg::RDSEL_HEX;
        default:           rdsel_o = soc_pkg::RDSEL_NONE;
      endcase
    end
  end

  // Write strobes follow the selected target.
  assign ram_we_o = wr && (rdsel_o == soc_pkg::RDSEL_MEM);
  assign led_we_o = wr && (rdsel_o == soc_pkg::RDSEL_LEDS);
  assign hex_we_o = wr && (rdsel_o == soc_pkg::RDSEL_HEX);

endmodule

`default_nettype wire

//--- design/data_ram.sv
`timescale 1ns/1ps
`default_nettype none

module data_ram (
  input  wire                     clk_i,
  input  wire                     arst_n_i,
  input  soc_pkg::bus_req_t       bus_i,
  input  wire                     we_i,
  output logic             [31:0] data_rdata_o,
  input  wire              [31:0] instr_addr_i,
  output logic             [31:0] instr_rdata_o
);

  logic [31:0]                mem_q [soc_pkg::RAM_WORDS];
  logic [soc_pkg::RAM_AW-1:0] data_widx;
  logic [soc_pkg::RAM_AW-1:0] instr_widx;

  // Both ports address whole words.
  assign data_widx  = bus_i.addr[soc_pkg::RAM_AW+1:2];
  assign instr_widx = instr_addr_i[soc_pkg::RAM_AW+1:2];

  ////////////////////////////////////////////////////////////
  // Write port
  ////////////////////////////////////////////////////////////

  // Writes are ignored while the system is held in reset.
  always_ff @(posedge clk_i) begin
    if (arst_n_i && we_i) begin
      for (int lane = 0; lane < 4; lane++) begin
        if (bus_i.be[lane]) begin
          mem_q[data_widx][8*lane +: 8] <= bus_i.wdata[8*lane +: 8];
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Read ports
  ////////////////////////////////////////////////////////////

  assign data_rdata_o  = mem_q[data_widx];
  assign instr_rdata_o = mem_q[instr_widx]; // Fetch sees the same array.

endmodule

`default_nettype wire

//--- design/led_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module led_ctrl (
  input  wire                     clk_i,
  input  wire                     arst_n_i,
  input  soc_pkg::bus_req_t       bus_i,
  input  wire                     we_i,
  output logic             [15:0] leds_o
);

  logic [15:0] leds_q;

  // Only the two low byte lanes reach the register.
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      leds_q <= '0;
    end else if (we_i) begin
      for (int lane = 0; lane < 2; lane++) begin
        if (bus_i.be[lane]) begin
          leds_q[8*lane +: 8] <= bus_i.wdata[8*lane +: 8];
        end
      end
    end
  end

  assign leds_o = leds_q;

endmodule

`default_nettype wire

//--- design/hex_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module hex_ctrl (
  input  wire                     clk_i,
  input  wire                     arst_n_i,
  input  soc_pkg::bus_req_t       bus_i,
  input  wire                     we_i,
  output logic             [15:0] hex_o,
  output logic             [6:0]  seg_o,
  output logic             [3:0]  an_o
);

  soc_pkg::hex_word_u               hex_q;
  logic [soc_pkg::HEX_SCAN_BITS-1:0] presc_q;
  logic [1:0]                       digit_q;
  logic [3:0]                       nibble;
  logic [6:0]                       seg_on;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      hex_q <= '0;
    end else if (we_i) begin
      for (int lane = 0; lane < 2; lane++) begin
        if (bus_i.be[lane]) hex_q.bytes[lane] <= bus_i.wdata[8*lane +: 8];
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Digit scanner
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      presc_q <= '0;
      digit_q <= '0;
    end else begin
      presc_q <= presc_q + 1'b1;
      if (&presc_q) digit_q <= digit_q + 1'b1; // Prescaler wraps.
    end
  end

  assign nibble = hex_q.digits[digit_q];

  // Segment order is {g, f, e, d, c, b, a}, lit when high.
  always_comb begin
    case (nibble)
      4'h0: seg_on = 7'h3f;
      4'h1: seg_on = 7'h06;
      4'h2: seg_on = 7'h5b;
      4'h3: seg_on = 7'h4f;
      4'h4: seg_on = 7'h66;
      4'h5: seg_on = 7'h6d;
      4'h6: seg_on = 7'h7d;
      4'h7: seg_on = 7'h07;
      4'h8: seg_on = 7'h7f;
      4'h9: seg_on = 7'h6f;
      4'ha: seg_on = 7'h77;
      4'hb: seg_on = 7'h7c;
      4'hc: seg_on = 7'h39;
      4'hd: seg_on = 7'h5e;
      4'he: seg_on = 7'h79;
      default: seg_on = 7'h71;
    endcase
  end

  assign seg_o = ~seg_on;                  // Display is active low.
  assign an_o  = ~(4'b0001 << digit_q);
  assign hex_o = hex_q;

endmodule

`default_nettype wire

//--- design/irq_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module irq_ctrl (
  input  wire         clk_i,
  input  wire         arst_n_i,
  input  wire  [31:0] int_req_i,
  input  wire  [31:0] mie_i,
  input  wire         irq_ack_i,
  output logic        irq_o,
  output logic [31:0] mcause_o,
  output logic [31:0] int_fin_o
);

  logic [31:0] masked;
  logic        any_req;
  logic [4:0]  prio_idx;
  logic        busy_q;
  logic [4:0]  idx_q;
  logic [31:0] fin_q;

  assign masked  = int_req_i & mie_i;
  assign any_req = |masked;

  // Lowest set index wins, so scan from the top down.
  always_comb begin
    prio_idx = '0;
    for (int i = 31; i >= 0; i--) begin
      if (masked[i]) prio_idx = 5'(i);
    end
  end

  ////////////////////////////////////////////////////////////
  // Idle and serving state
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      busy_q <= 1'b0;
      idx_q  <= '0;
      fin_q  <= '0;
    end else begin
      fin_q <= '0;
      if (!busy_q) begin
        if (any_req) begin
          busy_q <= 1'b1;
          idx_q  <= prio_idx;
        end
      end else if (irq_ack_i) begin
        busy_q       <= 1'b0;
        fin_q[idx_q] <= 1'b1;  // One cycle completion pulse.
      end
    end
  end

  assign irq_o     = busy_q;
  assign mcause_o  = {soc_pkg::IRQ_CAUSE_FLAG, 26'd0, idx_q};
  assign int_fin_o = fin_q;

endmodule

`default_nettype wire

//--- design/periph_top.sv
`timescale 1ns/1ps
`default_nettype none

module periph_top (
  input  wire                     clk_i,
  input  wire                     arst_n_i,
  input  soc_pkg::bus_req_t       bus_i,
  output logic             [31:0] data_rdata_o,
  input  wire              [31:0] instr_addr_i,
  output logic             [31:0] instr_rdata_o,
  input  wire              [31:0] int_req_i,
  input  wire              [31:0] mie_i,
  input  wire                     irq_ack_i,
  output logic                    irq_o,
  output logic             [31:0] mcause_o,
  output logic             [31:0] int_fin_o,
  output logic             [15:0] leds_o,
  output logic             [6:0]  seg_o,
  output logic             [3:0]  an_o
);

  logic            ram_we;
  logic            led_we;
  logic            hex_we;
  soc_pkg::rdsel_e rdsel;
  logic [31:0]     ram_rdata;
  logic [15:0]     hex_val;

  addr_decoder i_addr_decoder (
    .bus_i    (bus_i),
    .ram_we_o (ram_we),
    .led_we_o (led_we),
    .hex_we_o (hex_we),
    .rdsel_o  (rdsel)
  );

  data_ram i_data_ram (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .bus_i         (bus_i),
    .we_i          (ram_we),
    .data_rdata_o  (ram_rdata),
    .instr_addr_i  (instr_addr_i),
    .instr_rdata_o (instr_rdata_o)
  );

  led_ctrl i_led_ctrl (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .bus_i    (bus_i),
    .we_i     (led_we),
    .leds_o   (leds_o)
  );

  hex_ctrl i_hex_ctrl (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .bus_i    (bus_i),
    .we_i     (hex_we),
    .hex_o    (hex_val),
    .seg_o    (seg_o),
    .an_o     (an_o)
  );

  irq_ctrl i_irq_ctrl (
    .clk_i     (clk_i),
    .arst_n_i  (arst_n_i),
    .int_req_i (int_req_i),
    .mie_i     (mie_i),
    .irq_ack_i (irq_ack_i),
    .irq_o     (irq_o),
    .mcause_o  (mcause_o),
    .int_fin_o (int_fin_o)
  );

  // Unmapped and invalid addresses read as zero.
  always_comb begin
    case (rdsel)
      soc_pkg::RDSEL_MEM:  data_rdata_o = ram_rdata;
      soc_pkg::RDSEL_LEDS: data_rdata_o = {16'd0, leds_o};
      soc_pkg::RDSEL_HEX:  data_rdata_o = {16'd0, hex_val};
      default:             data_rdata_o = '0;
    endcase
  end

endmodule

`default_nettype wire

//--- tests/periph_checker.sv
`timescale 1ns/1ps
`default_nettype none

module periph_checker (
  input wire               clk_i,
  input wire               arst_n_i,
  input soc_pkg::bus_req_t bus_i,
  input wire               ram_we_i,
  input wire         [3:0] an_i,
  input wire               irq_i,
  input wire               irq_ack_i,
  input wire        [31:0] int_fin_i
);

  a_one_anode: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    $countones(~an_i) == 1)
    else $error("an_o does not select exactly one digit.");

  a_fin_onehot: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    $onehot0(int_fin_i))
    else $error("int_fin_o has more than one bit set.");

  // A completion pulse needs an acknowledged interrupt in the cycle before.
  a_fin_after_ack: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (int_fin_i != '0) |-> $past(irq_i && irq_ack_i))
    else $error("int_fin_o pulsed without an acknowledged interrupt.");

  a_ram_we_valid: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    ram_we_i |-> (bus_i.addr < soc_pkg::RAM_SIZE))
    else $error("RAM write strobe raised for an address outside the RAM.");

endmodule

bind periph_top periph_checker i_periph_checker (
  .clk_i     (clk_i),
  .arst_n_i  (arst_n_i),
  .bus_i     (bus_i),
  .ram_we_i  (ram_we),
  .an_i      (an_o),
  .irq_i     (irq_o),
  .irq_ack_i (irq_ack_i),
  .int_fin_i (int_fin_o)
);

`default_nettype wire

//--- tests/periph_tb.sv
`timescale 1ns/1ps
`default_nettype none

module periph_tb;

  logic               clk = 1'b0;
  logic               arst_n;
  soc_pkg::bus_req_t  bus_req;
  logic [31:0]        instr_addr;
  logic [31:0]        int_req;
  logic [31:0]        mie;
  logic               irq_ack;
  logic [31:0]        data_rdata;
  logic [31:0]        instr_rdata;
  logic               irq;
  logic [31:0]        mcause;
  logic [31:0]        int_fin;
  logic [15:0]        leds;
  logic [6:0]         seg;
  logic [3:0]         an;

  logic [31:0]        shadow_ram [soc_pkg::RAM_WORDS];
  logic [15:0]        led_model;
  soc_pkg::hex_word_u hex_model;
  logic [31:0]        rng = 32'h81f6;
  logic [31:0]        edge_cnt;

  periph_top i_periph_top (
    .clk_i         (clk),
    .arst_n_i      (arst_n),
    .bus_i         (bus_req),
    .data_rdata_o  (data_rdata),
    .instr_addr_i  (instr_addr),
    .instr_rdata_o (instr_rdata),
    .int_req_i     (int_req),
    .mie_i         (mie),
    .irq_ack_i     (irq_ack),
    .irq_o         (irq),
    .mcause_o      (mcause),
    .int_fin_o     (int_fin),
    .leds_o        (leds),
    .seg_o         (seg),
    .an_o          (an)
  );

  always #50 clk = ~clk;

  // Edges seen since reset release. The scan prescaler counts the same edges.
  always @(posedge clk or negedge arst_n) begin
    if (!arst_n) edge_cnt <= '0;
    else edge_cnt <= edge_cnt + 32'd1;
  end

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    return y ^ (y << 5);
  endfunction

  task automatic next_rand(output logic [31:0] r);
    rng = xorshift(rng);
    r   = rng;
  endtask

  function automatic logic [31:0] page_addr(input logic [3:0] page);
    return soc_pkg::PERIPH_BASE | {16'd0, page, 12'd0};
  endfunction

  function automatic logic [6:0] seg_low(input logic [3:0] nibble);
    logic [15:0][6:0] tbl;   // Active-low patterns, digit F first.
    tbl = {7'h0e, 7'h06, 7'h21, 7'h46, 7'h03, 7'h08, 7'h10, 7'h00,
           7'h78, 7'h02, 7'h12, 7'h19, 7'h30, 7'h24, 7'h79, 7'h40};
    return tbl[nibble];
  endfunction

  function automatic logic [4:0] lowest_index(input logic [31:0] bits);
    int i;
    i = 0;
    while (i < 31 && !bits[i]) i++;
    return 5'(i);
  endfunction

  task automatic step();
    @(posedge clk);
    #1;
  endtask

  task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                             input string what);
    assert (got === exp) else begin
      $display("FAILED at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
      $display("CHECKS FAILED");
      $fatal(1, "Stopped at the first mismatch.");
    end
  endtask

  task automatic bus_write(input logic [31:0] addr, input logic [3:0] be,
                           input logic [31:0] wdata);
    bus_req = {1'b1, 1'b1, be, addr, wdata};
    step();                                  // Taken at this edge.
    bus_req = '0;
  endtask

  task automatic bus_read_check(input logic [31:0] addr, input logic [31:0] exp,
                                input string what);
    bus_req = {1'b1, 1'b0, 4'hf, addr, 32'd0};
    #1;
    check_value(data_rdata, exp, what);
    bus_req = '0;
  endtask

  task automatic ram_write(input logic [31:0] addr, input logic [3:0] be,
                           input logic [31:0] wdata);
    bus_write(addr, be, wdata);
    for (int lane = 0; lane < 4; lane++) begin
      if (be[lane]) shadow_ram[addr[soc_pkg::RAM_AW+1:2]][8*lane +: 8] = wdata[8*lane +: 8];
    end
  endtask

  // Data and fetch ports look at the same word.
  task automatic ram_check(input logic [31:0] addr);
    instr_addr = addr;
    bus_read_check(addr, shadow_ram[addr[soc_pkg::RAM_AW+1:2]], "RAM data read");
    check_value(instr_rdata, shadow_ram[addr[soc_pkg::RAM_AW+1:2]], "RAM fetch read");
  endtask

  task automatic led_write(input logic [3:0] be, input logic [31:0] wdata);
    bus_write(page_addr(soc_pkg::LED_PAGE) | {20'd0, wdata[11:2], 2'b00}, be, wdata);
    for (int lane = 0; lane < 2; lane++) begin
      if (be[lane]) led_model[8*lane +: 8] = wdata[8*lane +: 8];
    end
  endtask

  task automatic hex_write(input logic [3:0] be, input logic [31:0] wdata);
    bus_write(page_addr(soc_pkg::HEX_PAGE), be, wdata);
    for (int lane = 0; lane < 2; lane++) begin
      if (be[lane]) hex_model.bytes[lane] = wdata[8*lane +: 8];
    end
  endtask

  task automatic invalid_access(input logic [31:0] addr);
    bus_write(addr, 4'hf, 32'hdead_beef);
    bus_read_check(addr, 32'd0, "read from an invalid address");
    ram_check({22'd0, addr[9:2], 2'b00}); // The aliased RAM word must be intact.
    check_value(32'(leds), 32'(led_model), "leds_o after invalid write");
  endtask

  task automatic wait_irq(input int max_cycles);
    int waited;
    waited = 0;
    while (!irq) begin
      if (waited == max_cycles) begin
        $display("CHECKS FAILED");
        $fatal(1, "Timed out waiting for irq_o to rise.");
      end else begin
        step();
        waited++;
      end
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////

  initial begin
    logic [31:0] r0;
    logic [31:0] r1;
    logic [31:0] addr;
    logic [4:0]  idx;
    arst_n     = 1'b0;
    bus_req    = '0;
    instr_addr = '0;
    int_req    = '0;
    mie        = '0;
    irq_ack    = 1'b0;
    led_model  = '0;
    hex_model  = '0;
    repeat (3) @(posedge clk);
    #1;
    arst_n = 1'b1;

    // Known contents everywhere before random traffic.
    for (int w = 0; w < soc_pkg::RAM_WORDS; w++) begin
      addr = 32'(w) << 2;
      ram_write(addr, 4'hf, {addr[15:0] ^ 16'h5a5a, addr[15:0]});
    end

    for (int n = 0; n < 64; n++) begin
      next_rand(r0);
      next_rand(r1);
      addr = {22'd0, r0[9:2], 2'b00};
      ram_write(addr, r0[31:28], r1);
      ram_check(addr);
      ram_check({22'd0, r1[19:12], 2'b00});
    end

    for (int n = 0; n < 8; n++) begin
      next_rand(r0);
      led_write(r0[31:28], r0);
      bus_read_check(page_addr(soc_pkg::LED_PAGE), {16'd0, led_model}, "LED readback");
      check_value(32'(leds), 32'(led_model), "leds_o");
      next_rand(r1);
      hex_write(r1[31:28], r1);
      bus_read_check(page_addr(soc_pkg::HEX_PAGE), {16'd0, hex_model}, "hex readback");
    end

    invalid_access(soc_pkg::RAM_SIZE);
    invalid_access(soc_pkg::PERIPH_END);
    invalid_access(page_addr(4'd3));
    invalid_access(32'h4000_0000);

    next_rand(r0);
    hex_write(4'h3, r0);
    for (int n = 0; n < 16; n++) begin
      check_value(32'(an), 32'(4'hf ^ (4'h1 << edge_cnt[3:2])), "an_o digit select");
      check_value(32'(seg), 32'(seg_low(hex_model.digits[edge_cnt[3:2]])), "seg_o pattern");
      step();
    end

    for (int n = 0; n < 24; n++) begin
      next_rand(r0);
      next_rand(r1);
      if (n % 4 == 3) r1 = ~r0;               // Every request masked off.
      int_req = r0;
      mie     = r1;
      if ((r0 & r1) == '0) begin
        repeat (4) begin
          step();
          check_value(32'(irq), 32'd0, "irq_o with all requests masked");
        end
      end else begin
        idx = lowest_index(r0 & r1);
        wait_irq(8);
        check_value(mcause, {soc_pkg::IRQ_CAUSE_FLAG, 26'd0, idx}, "mcause_o");
        int_req = '0;
        irq_ack = 1'b1;
        step();
        irq_ack = 1'b0;
        check_value(int_fin, 32'd1 << idx, "int_fin_o pulse");
        check_value(32'(irq), 32'd0, "irq_o after acknowledge");
        step();
        check_value(int_fin, 32'd0, "int_fin_o after the pulse");
      end
    end

    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- tb.f
design/soc_pkg.sv
design/addr_decoder.sv
design/data_ram.sv
design/led_ctrl.sv
design/hex_ctrl.sv
design/irq_ctrl.sv
design/periph_top.sv
tests/periph_checker.sv
tests/periph_tb.sv

//--- Makefile
TOP = periph_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f tb.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f tb.f
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
